// File: common/vlane_params.svh
// Vector lane group parameters: lane count, byte widths and register read latency
`ifndef VLANE_PARAMS_SVH
`define VLANE_PARAMS_SVH

// Lanes in the group
`define VLANE_NUM 8

// Bytes per lane word
`define LANE_BYTES 4

// Bits needed to address one lane
`define LANE_SEL_W 3

// Issue to vector read data, in cycles
`define READ_LATENCY 3

`define IMM_W 5     // Immediate operand width

`endif

// File: common/vlane_pkg.sv
// Vector lane package: lane, element and control types shared by the ALU cluster
`default_nettype none
`include "vlane_params.svh"

package vlane_pkg;

   typedef logic [8*`LANE_BYTES-1:0] lane_word_t;   // One lane word
   typedef logic [7:0]               lane_byte_t;
   typedef logic [`LANE_SEL_W-1:0]   lane_idx_t;    // Lane number, also slide amount
   typedef logic [1:0]               byte_sel_t;    // Byte within a lane word
   typedef logic [`IMM_W-1:0]        imm_t;

   typedef enum logic [1:0] {SEW_8 = 2'd0, SEW_16 = 2'd1, SEW_32 = 2'd2} sew_e;

   typedef enum logic [2:0] {
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLIDE_UP, OP_SLIDE_DOWN
   } alu_op_e;

   typedef enum logic [1:0] {OP2_VECTOR, OP2_SCALAR, OP2_IMM} op2_sel_e;

   typedef lane_word_t lane_words_t [`VLANE_NUM];   // All lanes side by side

   // Bits that are live for a given element width
   function automatic lane_word_t sew_mask(input sew_e sew);
      case (sew)
         SEW_8:   return lane_word_t'(32'h0000_00ff);
         SEW_16:  return lane_word_t'(32'h0000_ffff);
         default: return '1;
      endcase
   endfunction

endpackage

`default_nettype wire

// File: src/operand_delay.sv
// Operand delay: carries issue-time control fields to the vector read data cycle
`default_nettype none
`include "vlane_params.svh"

module operand_delay (
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,
   input  wire logic                  issue_i,
   input  wire vlane_pkg::alu_op_e    op_i,
   input  wire vlane_pkg::sew_e       sew_i,
   input  wire vlane_pkg::op2_sel_e   op2_sel_i,
   input  wire vlane_pkg::lane_word_t scalar_i,
   input  wire vlane_pkg::imm_t       imm_i,
   input  wire vlane_pkg::lane_idx_t  slide_amt_i,
   input  wire vlane_pkg::byte_sel_t  byte_sel_i,
   output logic                       dly_vld_o,
   output vlane_pkg::alu_op_e         op_o,
   output vlane_pkg::sew_e            sew_o,
   output vlane_pkg::op2_sel_e        op2_sel_o,
   output vlane_pkg::lane_word_t      scalar_o,
   output vlane_pkg::imm_t            imm_o,
   output vlane_pkg::lane_idx_t       slide_amt_o,
   output vlane_pkg::byte_sel_t       byte_sel_o
);
   import vlane_pkg::*;

   localparam int DEPTH = `READ_LATENCY;

   // One slot per instruction in flight
   logic       vld_q       [DEPTH];
   alu_op_e    op_q        [DEPTH];
   sew_e       sew_q       [DEPTH];
   op2_sel_e   op2_sel_q   [DEPTH];
   lane_word_t scalar_q    [DEPTH];
   imm_t       imm_q       [DEPTH];
   lane_idx_t  slide_amt_q [DEPTH];
   byte_sel_t  byte_sel_q  [DEPTH];

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         vld_q <= '{default: 1'b0};
      else
      begin
         vld_q[0] <= issue_i;
         for (int i = 1; i < DEPTH; i++)
            vld_q[i] <= vld_q[i-1];
      end
   end

   always_ff @(posedge clk_i)
   begin
      op_q[0]        <= op_i;
      sew_q[0]       <= sew_i;
      op2_sel_q[0]   <= op2_sel_i;
      scalar_q[0]    <= scalar_i;
      imm_q[0]       <= imm_i;
      slide_amt_q[0] <= slide_amt_i;
      byte_sel_q[0]  <= byte_sel_i;
      for (int i = 1; i < DEPTH; i++)
      begin
         op_q[i]        <= op_q[i-1];
         sew_q[i]       <= sew_q[i-1];
         op2_sel_q[i]   <= op2_sel_q[i-1];
         scalar_q[i]    <= scalar_q[i-1];
         imm_q[i]       <= imm_q[i-1];
         slide_amt_q[i] <= slide_amt_q[i-1];
         byte_sel_q[i]  <= byte_sel_q[i-1];
      end
   end

   // Last slot lines up with the read data
   assign dly_vld_o   = vld_q[DEPTH-1];
   assign op_o        = op_q[DEPTH-1];
   assign sew_o       = sew_q[DEPTH-1];
   assign op2_sel_o   = op2_sel_q[DEPTH-1];
   assign scalar_o    = scalar_q[DEPTH-1];
   assign imm_o       = imm_q[DEPTH-1];
   assign slide_amt_o = slide_amt_q[DEPTH-1];
   assign byte_sel_o  = byte_sel_q[DEPTH-1];

endmodule

`default_nettype wire

// File: src/slide_xbar.sv
// Slide crossbar: moves one selected byte per lane up or down by the slide amount
`default_nettype none
`include "vlane_params.svh"

module slide_xbar (
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,
   input  wire vlane_pkg::lane_words_t vs2_i,
   input  wire vlane_pkg::alu_op_e     op_i,
   input  wire vlane_pkg::lane_idx_t   slide_amt_i,
   input  wire vlane_pkg::byte_sel_t   byte_sel_i,
   output vlane_pkg::lane_words_t      slide_o
);
   import vlane_pkg::*;

   lane_words_t slide_d;

   //////////////////////////////////////////////////////////////////////
   // Eight-to-one byte mux per lane, index wraps at the lane count
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      lane_idx_t  src;
      lane_byte_t pick;
      for (int l = 0; l < `VLANE_NUM; l++)
      begin
         if (op_i == OP_SLIDE_UP)
            src = lane_idx_t'(l) - slide_amt_i;   // Up takes from lower lanes
         else
            src = lane_idx_t'(l) + slide_amt_i;
         pick       = vs2_i[src][8*byte_sel_i +: 8];
         slide_d[l] = {`LANE_BYTES{pick}};        // Byte enables pick it later
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         slide_o <= '{default: '0};
      else
         slide_o <= slide_d;
   end

endmodule

`default_nettype wire

// File: alu_cluster/sew_packer.sv
// SEW packer: gathers lane bytes into elements and picks the second ALU operand
`default_nettype none
`include "vlane_params.svh"

module sew_packer (
   input  wire vlane_pkg::lane_words_t vs1_i,
   input  wire vlane_pkg::lane_words_t vs2_i,
   input  wire vlane_pkg::sew_e        sew_i,
   input  wire vlane_pkg::op2_sel_e    op2_sel_i,
   input  wire vlane_pkg::lane_word_t  scalar_i,
   input  wire vlane_pkg::imm_t        imm_i,
   output vlane_pkg::lane_words_t      opa_o,
   output vlane_pkg::lane_words_t      opb_o
);
   import vlane_pkg::*;

   // Element for slice s, built from byte (s mod group) of each lane in its group
   function automatic lane_word_t gather(input lane_words_t vs, input sew_e sew,
                                         input int s);
      int         base;
      int         b;
      lane_word_t w;
      w = '0;
      case (sew)
         SEW_16:
         begin
            base = s - (s % 2);
            b    = s % 2;
            w[15:0] = {vs[base+1][8*b +: 8], vs[base][8*b +: 8]};
         end
         SEW_32:
         begin
            base = s - (s % 4);
            b    = s % 4;
            w = {vs[base+3][8*b +: 8], vs[base+2][8*b +: 8],
                 vs[base+1][8*b +: 8], vs[base][8*b +: 8]};
         end
         default: w[7:0] = vs[s][7:0];
      endcase
      return w;
   endfunction

   lane_word_t mask;
   lane_word_t imm_ext;

   assign mask    = sew_mask(sew_i);
   assign imm_ext = {{($bits(lane_word_t)-`IMM_W){imm_i[`IMM_W-1]}}, imm_i};

   always_comb
   begin
      for (int s = 0; s < `VLANE_NUM; s++)
      begin
         opa_o[s] = gather(vs1_i, sew_i, s);
         case (op2_sel_i)
            OP2_SCALAR: opb_o[s] = scalar_i & mask;   // Low element bits only
            OP2_IMM:    opb_o[s] = imm_ext & mask;
            default:    opb_o[s] = gather(vs2_i, sew_i, s);
         endcase
      end
   end

endmodule

`default_nettype wire

// File: alu_cluster/lane_alu.sv
// Lane ALU: eight registered element slices for add, sub and the bitwise ops
`default_nettype none
`include "vlane_params.svh"

module lane_alu (
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,
   input  wire logic                   vld_i,
   input  wire vlane_pkg::alu_op_e     op_i,
   input  wire vlane_pkg::sew_e        sew_i,
   input  wire vlane_pkg::lane_words_t opa_i,
   input  wire vlane_pkg::lane_words_t opb_i,
   output logic                        vld_o,
   output vlane_pkg::alu_op_e          op_o,
   output vlane_pkg::sew_e             sew_o,
   output vlane_pkg::lane_words_t      res_o
);
   import vlane_pkg::*;

   lane_word_t mask;

   assign mask = sew_mask(sew_i);

   //////////////////////////////////////////////////////////////////////
   // Element slices
   //////////////////////////////////////////////////////////////////////
   for (genvar s = 0; s < `VLANE_NUM; s++)
   begin : gen_slice
      lane_word_t res_d;

      always_comb
      begin
         case (op_i)
            OP_ADD:  res_d = opa_i[s] + opb_i[s];
            OP_SUB:  res_d = opa_i[s] - opb_i[s];
            OP_AND:  res_d = opa_i[s] & opb_i[s];
            OP_OR:   res_d = opa_i[s] | opb_i[s];
            OP_XOR:  res_d = opa_i[s] ^ opb_i[s];
            default: res_d = '0;               // Slides bypass the slices
         endcase
      end

      always_ff @(posedge clk_i)
         res_o[s] <= res_d & mask;             // Drop carry out of the element
   end

   // Scatter needs width and opcode in the result cycle
   always_ff @(posedge clk_i)
   begin
      op_o  <= op_i;
      sew_o <= sew_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         vld_o <= 1'b0;
      else
         vld_o <= vld_i;
   end

endmodule

`default_nettype wire

// File: alu_cluster/result_scatter.sv
// Result scatter: returns element results to lane bytes or passes slide data through
`default_nettype none
`include "vlane_params.svh"

module result_scatter (
   input  wire vlane_pkg::lane_words_t res_i,
   input  wire vlane_pkg::lane_words_t slide_i,
   input  wire vlane_pkg::alu_op_e     op_i,
   input  wire vlane_pkg::sew_e        sew_i,
   output vlane_pkg::lane_words_t      word_o
);
   import vlane_pkg::*;

   lane_words_t scat;

   //////////////////////////////////////////////////////////////////////
   // Inverse of the packer gather
   //////////////////////////////////////////////////////////////////////
   always_comb
   begin
      int base;
      int j;
      for (int l = 0; l < `VLANE_NUM; l++)
      begin
         case (sew_i)
            SEW_32:
            begin
               base = l - (l % 4);
               j    = l % 4;
               scat[l] = {res_i[base+3][8*j +: 8], res_i[base+2][8*j +: 8],
                          res_i[base+1][8*j +: 8], res_i[base][8*j +: 8]};
            end
            SEW_16:
            begin
               base = l - (l % 2);
               j    = l % 2;
               // Upper half repeats the lower
               scat[l] = {2{res_i[base+1][8*j +: 8], res_i[base][8*j +: 8]}};
            end
            default:
            begin
               base = l;
               j    = 0;
               scat[l] = {`LANE_BYTES{res_i[l][7:0]}};
            end
         endcase
      end
   end

   always_comb
   begin
      if (op_i == OP_SLIDE_UP || op_i == OP_SLIDE_DOWN)
         word_o = slide_i;
      else
         word_o = scat;
   end

endmodule

`default_nettype wire

// File: src/vlane_alu_cluster.sv
// Vector lane ALU cluster: aligns control, packs elements, computes and scatters results
`default_nettype none

module vlane_alu_cluster (
   input  wire logic                   clk_i,
   input  wire logic                   rst_i,
   // Issue side
   input  wire logic                   issue_i,
   input  wire vlane_pkg::alu_op_e     op_i,
   input  wire vlane_pkg::sew_e        sew_i,
   input  wire vlane_pkg::op2_sel_e    op2_sel_i,
   input  wire vlane_pkg::lane_word_t  scalar_i,
   input  wire vlane_pkg::imm_t        imm_i,
   input  wire vlane_pkg::lane_idx_t   slide_amt_i,
   input  wire vlane_pkg::byte_sel_t   byte_sel_i,
   // Register file read data
   input  wire logic                   vs_vld_i,
   input  wire vlane_pkg::lane_words_t vs1_i,
   input  wire vlane_pkg::lane_words_t vs2_i,
   // Results
   output logic                        res_vld_o,
   output vlane_pkg::lane_words_t      res_o
);
   import vlane_pkg::*;

   // Fields aligned with the read data
   logic        dly_vld;
   alu_op_e     dly_op;
   sew_e        dly_sew;
   op2_sel_e    dly_op2_sel;
   lane_word_t  dly_scalar;
   imm_t        dly_imm;
   lane_idx_t   dly_slide_amt;
   byte_sel_t   dly_byte_sel;

   logic        alu_vld;
   lane_words_t opa, opb;
   alu_op_e     res_op;
   sew_e        res_sew;
   lane_words_t alu_res;
   lane_words_t slide_word;

   // Data counts only when an issued instruction is due
   assign alu_vld = vs_vld_i & dly_vld;

   operand_delay u_operand_delay (
      .clk_i(clk_i), .rst_i(rst_i), .issue_i(issue_i),
      .op_i(op_i), .sew_i(sew_i), .op2_sel_i(op2_sel_i), .scalar_i(scalar_i),
      .imm_i(imm_i), .slide_amt_i(slide_amt_i), .byte_sel_i(byte_sel_i),
      .dly_vld_o(dly_vld), .op_o(dly_op), .sew_o(dly_sew), .op2_sel_o(dly_op2_sel),
      .scalar_o(dly_scalar), .imm_o(dly_imm), .slide_amt_o(dly_slide_amt),
      .byte_sel_o(dly_byte_sel)
   );

   sew_packer u_sew_packer (
      .vs1_i(vs1_i), .vs2_i(vs2_i), .sew_i(dly_sew), .op2_sel_i(dly_op2_sel),
      .scalar_i(dly_scalar), .imm_i(dly_imm), .opa_o(opa), .opb_o(opb)
   );

   lane_alu u_lane_alu (
      .clk_i(clk_i), .rst_i(rst_i), .vld_i(alu_vld), .op_i(dly_op), .sew_i(dly_sew),
      .opa_i(opa), .opb_i(opb),
      .vld_o(res_vld_o), .op_o(res_op), .sew_o(res_sew), .res_o(alu_res)
   );

   slide_xbar u_slide_xbar (
      .clk_i(clk_i), .rst_i(rst_i), .vs2_i(vs2_i), .op_i(dly_op),
      .slide_amt_i(dly_slide_amt), .byte_sel_i(dly_byte_sel), .slide_o(slide_word)
   );

   result_scatter u_result_scatter (
      .res_i(alu_res), .slide_i(slide_word), .op_i(res_op), .sew_i(res_sew),
      .word_o(res_o)
   );

endmodule

`default_nettype wire

// File: tests/vlane_properties.sv
// Vector lane ALU cluster timing assertions, bound to the top level
`default_nettype none
`include "vlane_params.svh"

module vlane_properties (
   input wire logic                   clk_i,
   input wire logic                   rst_i,
   input wire logic                   issue_i,
   input wire logic                   vs_vld_i,
   input wire logic                   res_vld_i,
   input wire vlane_pkg::lane_words_t res_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // Result valid is the read data valid one cycle later
   a_res_follows_data: assert property (@(posedge clk_i) disable iff (!rst_i)
      res_vld_i == $past(vs_vld_i))
   else $error("result valid does not follow read data valid by one cycle");

   // Read data only comes back for an issued instruction
   a_data_after_issue: assert property (@(posedge clk_i) disable iff (!rst_i)
      vs_vld_i |-> $past(issue_i, `READ_LATENCY))
   else $error("read data valid without an issue READ_LATENCY cycles before");

   for (genvar l = 0; l < `VLANE_NUM; l++)
   begin : gen_known
      a_res_known: assert property (@(posedge clk_i) disable iff (!rst_i)
         res_vld_i |-> !$isunknown(res_i[l]))
      else $error("result lane %0d has unknown bits while valid", l);
   end

endmodule

bind vlane_alu_cluster vlane_properties u_vlane_properties (
   .clk_i(clk_i), .rst_i(rst_i), .issue_i(issue_i), .vs_vld_i(vs_vld_i),
   .res_vld_i(res_vld_o), .res_i(res_o)
);

`default_nettype wire

// File: tests/vlane_tb.sv
// Vector lane ALU cluster testbench: stimulus table, register-file model and reference model
`default_nettype none
`include "vlane_params.svh"

module vlane_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import vlane_pkg::*;

   localparam int ROWS       = 24;
   localparam int RF_DEPTH   = `READ_LATENCY - 1;
   localparam int IDLE_LIMIT = 20;    // Cycles without a result before giving up

   logic        clk_i;
   logic        rst_i;
   logic        issue_i;
   alu_op_e     op_i;
   sew_e        sew_i;
   op2_sel_e    op2_sel_i;
   lane_word_t  scalar_i;
   imm_t        imm_i;
   lane_idx_t   slide_amt_i;
   byte_sel_t   byte_sel_i;
   logic        vs_vld_i;
   lane_words_t vs1_i;
   lane_words_t vs2_i;
   logic        res_vld_o;
   lane_words_t res_o;

   // Stimulus table
   alu_op_e     tbl_op     [ROWS];
   sew_e        tbl_sew    [ROWS];
   op2_sel_e    tbl_sel    [ROWS];
   imm_t        tbl_imm    [ROWS];
   lane_idx_t   tbl_amt    [ROWS];
   byte_sel_t   tbl_bsel   [ROWS];
   int          tbl_gap    [ROWS];   // Idle cycles before the issue
   lane_words_t tbl_vs1    [ROWS];
   lane_words_t tbl_vs2    [ROWS];
   lane_word_t  tbl_scalar [ROWS];
   lane_words_t tbl_exp    [ROWS];
   int          n_rows;

   int          issue_row;
   int          cycle;
   logic [31:0] lfsr_state;
   int          exp_cyc_q [$];
   int          exp_row_q [$];
   logic        rf_vld_q [RF_DEPTH];
   int          rf_row_q [RF_DEPTH];

   vlane_alu_cluster u_vlane_alu_cluster (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
      cycle <= cycle + 1;

   //////////////////////////////////////////////////////////////////////
   // Register-file model, replays operands READ_LATENCY cycles after issue
   //////////////////////////////////////////////////////////////////////
   always @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         for (int i = 0; i < RF_DEPTH; i++)
            rf_vld_q[i] <= 1'b0;
         vs_vld_i <= 1'b0;
      end
      else
      begin
         rf_vld_q[0] <= issue_i;
         rf_row_q[0] <= issue_row;
         for (int i = 1; i < RF_DEPTH; i++)
         begin
            rf_vld_q[i] <= rf_vld_q[i-1];
            rf_row_q[i] <= rf_row_q[i-1];
         end
         vs_vld_i <= rf_vld_q[RF_DEPTH-1];
         if (rf_vld_q[RF_DEPTH-1])
         begin
            vs1_i <= tbl_vs1[rf_row_q[RF_DEPTH-1]];
            vs2_i <= tbl_vs2[rf_row_q[RF_DEPTH-1]];
         end
         else
         begin
            vs1_i <= '{default: '0};
            vs2_i <= '{default: '0};
         end
      end
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("STATUS: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_valid(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
   endtask

   task automatic check_words(input string name, input lane_words_t got,
                              input lane_words_t exp);
      for (int l = 0; l < `VLANE_NUM; l++)
         if (got[l] !== exp[l])
            fail_run($sformatf("MISMATCH %s[%0d]: got %h expected %h",
                               name, l, got[l], exp[l]));
   endtask

   // Galois LFSR, taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b)
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      return b;
   endfunction

   function automatic lane_word_t rand_word();
      lane_word_t w;
      for (int i = 0; i < $bits(lane_word_t); i++)
         w[i] = lfsr_bit();
      return w;
   endfunction

   task automatic add_row(input alu_op_e op, input sew_e sew, input op2_sel_e sel,
                          input imm_t imm, input lane_idx_t amt, input byte_sel_t bsel,
                          input int gap);
      tbl_op[n_rows]   = op;
      tbl_sew[n_rows]  = sew;
      tbl_sel[n_rows]  = sel;
      tbl_imm[n_rows]  = imm;
      tbl_amt[n_rows]  = amt;
      tbl_bsel[n_rows] = bsel;
      tbl_gap[n_rows]  = gap;
      for (int l = 0; l < `VLANE_NUM; l++)
      begin
         tbl_vs1[n_rows][l] = rand_word();
         tbl_vs2[n_rows][l] = rand_word();
      end
      tbl_scalar[n_rows] = rand_word();
      n_rows++;
   endtask

   function automatic lane_word_t elem_mask(input int nbytes);
      lane_word_t m;
      m = '0;
      for (int i = 0; i < 8*nbytes; i++)
         m[i] = 1'b1;
      return m;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Reference model: gather, operate, truncate, scatter
   //////////////////////////////////////////////////////////////////////
   function automatic void model_result(input int r);
      lane_words_t out;
      lane_word_t  a;
      lane_word_t  b;
      lane_word_t  y;
      lane_word_t  m;
      int          n;
      int          src;
      int          imm_val;
      out = '{default: '0};
      if (tbl_op[r] == OP_SLIDE_UP || tbl_op[r] == OP_SLIDE_DOWN)
      begin
         for (int l = 0; l < `VLANE_NUM; l++)
         begin
            if (tbl_op[r] == OP_SLIDE_UP)
               src = (l - int'(tbl_amt[r]) + `VLANE_NUM) % `VLANE_NUM;
            else
               src = (l + int'(tbl_amt[r])) % `VLANE_NUM;
            out[l] = {`LANE_BYTES{tbl_vs2[r][src][8*tbl_bsel[r] +: 8]}};
         end
         tbl_exp[r] = out;
         return;
      end
      n = (tbl_sew[r] == SEW_32) ? 4 : ((tbl_sew[r] == SEW_16) ? 2 : 1);   // Lanes per element
      m = elem_mask(n);
      for (int g = 0; g < `VLANE_NUM; g += n)
         for (int p = 0; p < n; p++)                       // Byte position in the lane
         begin
            a = '0;
            b = '0;
            for (int j = 0; j < n; j++)
            begin
               a[8*j +: 8] = tbl_vs1[r][g+j][8*p +: 8];
               b[8*j +: 8] = tbl_vs2[r][g+j][8*p +: 8];
            end
            if (tbl_sel[r] == OP2_SCALAR)
               b = tbl_scalar[r] & m;
            else if (tbl_sel[r] == OP2_IMM)
            begin
               // Two's complement value of the immediate
               imm_val = int'(tbl_imm[r]);
               if (imm_val >= (1 << (`IMM_W-1)))
                  imm_val -= (1 << `IMM_W);
               b = lane_word_t'(imm_val) & m;
            end
            case (tbl_op[r])
               OP_ADD:  y = a + b;
               OP_SUB:  y = a - b;
               OP_AND:  y = a & b;
               OP_OR:   y = a | b;
               default: y = a ^ b;
            endcase
            y = y & m;
            for (int j = 0; j < n; j++)
               out[g+j][8*p +: 8] = y[8*j +: 8];
         end
      // Narrow elements repeat in the upper bytes
      for (int l = 0; l < `VLANE_NUM; l++)
         if (n == 1)
            out[l] = {`LANE_BYTES{out[l][7:0]}};
         else if (n == 2)
            out[l] = {2{out[l][15:0]}};
      tbl_exp[r] = out;
   endfunction

   task automatic load_table();
      add_row(OP_ADD,        SEW_8,  OP2_VECTOR, 5'h00, 3'd0, 2'd0, 6);   // Isolated
      add_row(OP_SUB,        SEW_16, OP2_VECTOR, 5'h00, 3'd0, 2'd0, 6);
      add_row(OP_ADD,        SEW_32, OP2_VECTOR, 5'h00, 3'd0, 2'd0, 6);
      add_row(OP_AND,        SEW_8,  OP2_VECTOR, 5'h00, 3'd0, 2'd0, 2);
      add_row(OP_OR,         SEW_16, OP2_VECTOR, 5'h00, 3'd0, 2'd0, 0);
      add_row(OP_XOR,        SEW_32, OP2_VECTOR, 5'h00, 3'd0, 2'd0, 0);
      add_row(OP_SUB,        SEW_32, OP2_VECTOR, 5'h00, 3'd0, 2'd0, 0);
      add_row(OP_ADD,        SEW_16, OP2_VECTOR, 5'h00, 3'd0, 2'd0, 0);
      add_row(OP_SUB,        SEW_8,  OP2_VECTOR, 5'h00, 3'd0, 2'd0, 0);
      add_row(OP_ADD,        SEW_16, OP2_SCALAR, 5'h00, 3'd0, 2'd0, 1);
      add_row(OP_XOR,        SEW_32, OP2_SCALAR, 5'h00, 3'd0, 2'd0, 0);
      add_row(OP_SUB,        SEW_8,  OP2_SCALAR, 5'h00, 3'd0, 2'd0, 0);
      add_row(OP_ADD,        SEW_8,  OP2_IMM,    5'h1d, 3'd0, 2'd0, 0);   // -3
      add_row(OP_SUB,        SEW_16, OP2_IMM,    5'h10, 3'd0, 2'd0, 0);   // -16
      add_row(OP_OR,         SEW_32, OP2_IMM,    5'h0f, 3'd0, 2'd0, 0);
      add_row(OP_SLIDE_UP,   SEW_8,  OP2_VECTOR, 5'h00, 3'd1, 2'd0, 2);
      add_row(OP_SLIDE_DOWN, SEW_8,  OP2_VECTOR, 5'h00, 3'd1, 2'd3, 0);
      add_row(OP_SLIDE_UP,   SEW_32, OP2_VECTOR, 5'h00, 3'd7, 2'd2, 0);
      add_row(OP_SLIDE_DOWN, SEW_16, OP2_VECTOR, 5'h00, 3'd5, 2'd1, 0);
      add_row(OP_SLIDE_UP,   SEW_8,  OP2_VECTOR, 5'h00, 3'd0, 2'd1, 0);
      add_row(OP_SLIDE_DOWN, SEW_8,  OP2_VECTOR, 5'h00, 3'd3, 2'd2, 0);
      add_row(OP_ADD,        SEW_32, OP2_VECTOR, 5'h00, 3'd0, 2'd0, 0);
      add_row(OP_SLIDE_DOWN, SEW_8,  OP2_VECTOR, 5'h00, 3'd2, 2'd0, 0);
      add_row(OP_AND,        SEW_16, OP2_IMM,    5'h0a, 3'd0, 2'd0, 0);
      for (int r = 0; r < n_rows; r++)
         model_result(r);
   endtask

   task automatic issue_rows();
      for (int r = 0; r < n_rows; r++)
      begin
         repeat (tbl_gap[r])
         begin
            @(posedge clk_i);
            issue_i <= 1'b0;
         end
         @(posedge clk_i);
         issue_i     <= 1'b1;
         op_i        <= tbl_op[r];
         sew_i       <= tbl_sew[r];
         op2_sel_i   <= tbl_sel[r];
         scalar_i    <= tbl_scalar[r];
         imm_i       <= tbl_imm[r];
         slide_amt_i <= tbl_amt[r];
         byte_sel_i  <= tbl_bsel[r];
         issue_row   <= r;
         // cycle still counts up to the previous edge here
         exp_cyc_q.push_back(cycle + `READ_LATENCY + 2);
         exp_row_q.push_back(r);
      end
      @(posedge clk_i);
      issue_i <= 1'b0;
   endtask

   // Valid must be high exactly in each expected cycle and low otherwise
   task automatic collect_results();
      int idle;
      int row;
      int checked;
      idle    = 0;
      checked = 0;
      while (checked < n_rows)
      begin
         @(negedge clk_i);
         if (exp_cyc_q.size() != 0 && exp_cyc_q[0] == cycle)
         begin
            row = exp_row_q.pop_front();
            void'(exp_cyc_q.pop_front());
            check_valid("res_vld_o", res_vld_o, 1'b1);
            check_words($sformatf("res_o row %0d", row), res_o, tbl_exp[row]);
            checked++;
            idle = 0;
         end
         else
         begin
            check_valid("res_vld_o", res_vld_o, 1'b0);
            idle++;
            if (idle > IDLE_LIMIT)
               fail_run("Timed out waiting for the next result");
         end
      end
   endtask

   initial
   begin
      rst_i       = 1'b0;
      issue_i     = 1'b0;
      op_i        = OP_ADD;
      sew_i       = SEW_8;
      op2_sel_i   = OP2_VECTOR;
      scalar_i    = '0;
      imm_i       = '0;
      slide_amt_i = '0;
      byte_sel_i  = '0;
      vs_vld_i    = 1'b0;
      vs1_i       = '{default: '0};
      vs2_i       = '{default: '0};
      issue_row   = 0;
      cycle       = 0;
      n_rows      = 0;
      lfsr_state  = 32'h58f2;
      load_table();

      repeat (2) @(posedge clk_i);
      rst_i <= 1'b1;
      @(negedge clk_i);
      check_valid("res_vld_o", res_vld_o, 1'b0);   // Quiet after reset

      fork
         issue_rows();
         collect_results();
      join

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/vlane_pkg.sv
src/operand_delay.sv
src/slide_xbar.sv
alu_cluster/sew_packer.sv
alu_cluster/lane_alu.sv
alu_cluster/result_scatter.sv
src/vlane_alu_cluster.sv
tests/vlane_properties.sv
tests/vlane_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the vector lane ALU cluster testbench with Verilator and runs it
# The exit status is the simulator's, non-zero on any failure

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir \
   && verilator --binary --timing --assert --timescale 1ns/100ps \
         -f all.f --top-module vlane_tb -Mdir obj_dir \
   && ./obj_dir/Vvlane_tb \
   || { echo "Build or simulation failed"; exit 1; }
